/* common/vm2_pkg.sv */
// shared definitions for the qbus unit
// bus cycle kinds, sequencer states, timing constants
package vm2_pkg;

   // kinds of bus cycle, host side and internal
   typedef enum logic [1:0] {
      op_read       = 2'd0,  // word read, din strobe
      op_write      = 2'd1,  // word write, dout strobe
      op_write_byte = 2'd2,  // byte write, wtbt in data phase
      op_iack       = 2'd3   // interrupt vector read
   } qbus_op_t;

   // sequencer states
   typedef enum logic [2:0] {
      st_idle      = 3'd0,  // waiting for request or virq
      st_addr      = 3'd1,  // address on ad, no sync yet
      st_data      = 3'd2,  // sync asserted, address held
      st_wait_rply = 3'd3,  // strobe out, waiting on reply
      st_release   = 3'd4,  // strobe dropped, wait rply off
      st_end       = 3'd5   // sync dropped, done pulse
   } seq_state_t;

   localparam int qbus_width = 16;    // address and data
   localparam int rply_timeout = 64;  // cycles from strobe to bus error
   localparam int init_cycles = 32;   // init pulse after reset
   localparam int sync_stages = 2;    // flops on async inputs

   // counter widths derived from the timing constants
   localparam int tmo_cnt_w = $clog2(rply_timeout);
   localparam int init_cnt_w = $clog2(init_cycles + 1);

endpackage

/* hdl/vm2_pin_sync.sv */
// input side of the qbus pins
// reply and interrupt synchronizers, address/data capture
// aligned with the synchronized reply
`timescale 1ns/1ps

module vm2_pin_sync (
   input  logic        pin_clk_p,   // bus clock, rising edge
   input  logic        rst,
   input  logic        rply_raw,    // reply, active high, async
   input  logic        virq_raw,    // vectored irq, async
   input  logic [15:0] ad_raw,      // ad bus, active high
   input  logic        strobe_act,  // din or dout out of the sequencer
   output logic        rply,
   output logic        virq,
   output logic [15:0] ad_in
);

   logic [vm2_pkg::sync_stages-1:0] rply_sr;       // bit 0 sees the pin
   logic [vm2_pkg::sync_stages-1:0] virq_sr;
   logic [15:0]                     ad_sr [vm2_pkg::sync_stages];  // data pipe

   always_ff @(posedge pin_clk_p) begin
      if (rst) begin
         rply_sr <= '0;
         virq_sr <= '0;
      end else begin
         rply_sr <= {rply_sr[vm2_pkg::sync_stages-2:0], rply_raw};
         virq_sr <= {virq_sr[vm2_pkg::sync_stages-2:0], virq_raw};
      end
   end

   // same depth as the reply chain so data is stable when rply shows
   always_ff @(posedge pin_clk_p) begin
      ad_sr[0] <= ad_raw;
      for (int i = 1; i < vm2_pkg::sync_stages; i++) begin
         ad_sr[i] <= ad_sr[i-1];
      end
   end

   assign rply  = rply_sr[vm2_pkg::sync_stages-1];   // last stage
   assign virq  = virq_sr[vm2_pkg::sync_stages-1];
   assign ad_in = ad_sr[vm2_pkg::sync_stages-1];

   // the slave only answers a strobe, so a reply must find one active
   a_rply_needs_strobe: assert property (
      @(posedge pin_clk_p) disable iff (rst)
      $rose(rply) |-> strobe_act
   );

endmodule

/* qbus/vm2_qbus_seq.sv */
// qbus cycle sequencer
// word read, word write, byte write and interrupt acknowledge
// reply timeout with bus error, host request port
`timescale 1ns/1ps

module vm2_qbus_seq (
   input  logic              pin_clk_p,   // bus clock
   input  logic              rst,
   input  logic              init_busy,   // init pulse still running
   input  logic              req_strobe,  // one-cycle host request
   input  vm2_pkg::qbus_op_t req_op,
   input  logic [15:0]       req_addr,
   input  logic [15:0]       req_wdata,
   input  logic              rply,        // synchronized reply
   input  logic              virq,        // synchronized irq
   input  logic [15:0]       ad_in,       // synchronized ad bus
   output logic              busy,
   output logic              done,
   output vm2_pkg::qbus_op_t done_op,
   output logic [15:0]       rd_data,
   output logic              bus_err,
   output logic [15:0]       ad_out,
   output logic              ad_ena,
   output logic              sync,
   output logic              din,
   output logic              dout,
   output logic              wtbt,
   output logic              iako
);

   vm2_pkg::seq_state_t state;
   vm2_pkg::qbus_op_t   op_q;       // operation in flight
   logic [15:0]         addr_q;
   logic [15:0]         wdata_q;
   logic                err_q;      // cycle ended by timeout
   logic [vm2_pkg::tmo_cnt_w-1:0] tmo_cnt;
   logic                is_wr;      // word or byte write
   logic                accept;     // host request taken
   logic                take_irq;   // interrupt served

   assign is_wr    = (op_q == vm2_pkg::op_write) || (op_q == vm2_pkg::op_write_byte);
   assign accept   = (state == vm2_pkg::st_idle) && !init_busy && req_strobe;
   assign take_irq = (state == vm2_pkg::st_idle) && !init_busy && !req_strobe && virq;

   always_ff @(posedge pin_clk_p) begin
      if (rst) begin
         state   <= vm2_pkg::st_idle;
         err_q   <= 1'b0;
         tmo_cnt <= '0;
      end else begin
         case (state)
            vm2_pkg::st_idle: begin
               tmo_cnt <= '0;
               if (accept) begin
                  err_q <= 1'b0;
                  if (req_op == vm2_pkg::op_iack) begin   // no address phase
                     state <= vm2_pkg::st_wait_rply;
                  end else begin
                     state <= vm2_pkg::st_addr;
                  end
               end else if (take_irq) begin
                  err_q <= 1'b0;
                  state <= vm2_pkg::st_wait_rply;
               end
            end
            vm2_pkg::st_addr: state <= vm2_pkg::st_data;
            vm2_pkg::st_data: state <= vm2_pkg::st_wait_rply;
            vm2_pkg::st_wait_rply: begin
               tmo_cnt <= tmo_cnt + 1'b1;
               if (rply) begin
                  state <= vm2_pkg::st_release;
               end else if (int'(tmo_cnt) == vm2_pkg::rply_timeout - 1) begin
                  err_q <= 1'b1;                  // nobody answered
                  state <= vm2_pkg::st_end;       // skip the rply wait
               end
            end
            vm2_pkg::st_release: begin
               if (!rply) begin
                  state <= vm2_pkg::st_end;
               end
            end
            vm2_pkg::st_end: state <= vm2_pkg::st_idle;
            default:         state <= vm2_pkg::st_idle;
         endcase
      end
   end

   // request payload and captured read data
   always_ff @(posedge pin_clk_p) begin
      if (accept) begin
         op_q    <= req_op;
         addr_q  <= req_addr;
         wdata_q <= req_wdata;
      end else if (take_irq) begin
         op_q <= vm2_pkg::op_iack;
      end
      if (state == vm2_pkg::st_wait_rply && rply) begin
         rd_data <= ad_in;                        // data or vector
      end
   end

   // bus levels from state, registered again in the drive block
   always_comb begin
      ad_out = addr_q;
      ad_ena = 1'b0;
      sync   = 1'b0;
      din    = 1'b0;
      dout   = 1'b0;
      wtbt   = 1'b0;
      iako   = 1'b0;
      case (state)
         vm2_pkg::st_addr: begin
            ad_ena = 1'b1;
            wtbt   = is_wr;                       // write flagged with address
         end
         vm2_pkg::st_data: begin
            ad_ena = 1'b1;
            wtbt   = is_wr;
            sync   = 1'b1;
         end
         vm2_pkg::st_wait_rply: begin
            if (op_q == vm2_pkg::op_iack) begin
               din  = 1'b1;
               iako = 1'b1;
            end else if (is_wr) begin
               ad_out = wdata_q;
               ad_ena = 1'b1;
               wtbt   = (op_q == vm2_pkg::op_write_byte);  // byte select by a[0]
               dout   = 1'b1;
               sync   = 1'b1;
            end else begin
               din  = 1'b1;                       // ad released for the slave
               sync = 1'b1;
            end
         end
         vm2_pkg::st_release: sync = (op_q != vm2_pkg::op_iack);
         default: ;
      endcase
   end

   assign busy    = (state != vm2_pkg::st_idle) || init_busy;
   assign done    = (state == vm2_pkg::st_end);
   assign done_op = op_q;
   assign bus_err = err_q;

   a_no_din_dout: assert property (
      @(posedge pin_clk_p) disable iff (rst) !(din && dout)
   );

   // sync already up one cycle before a data strobe, iack excepted
   a_strobe_in_sync: assert property (
      @(posedge pin_clk_p) disable iff (rst)
      ($rose(din || dout) && op_q != vm2_pkg::op_iack) |-> $past(sync)
   );

   a_no_req_when_busy: assert property (
      @(posedge pin_clk_p) disable iff (rst) !(req_strobe && busy)
   );

endmodule

/* hdl/vm2_pin_drive.sv */
// output side of the qbus pins
// output pin registers and the init pulse timer
`timescale 1ns/1ps

module vm2_pin_drive (
   input  logic        pin_clk_p,  // bus clock
   input  logic        rst,
   input  logic [15:0] ad_out_d,   // levels from the sequencer
   input  logic        ad_ena_d,
   input  logic        sync_d,
   input  logic        din_d,
   input  logic        dout_d,
   input  logic        wtbt_d,
   input  logic        iako_d,
   output logic [15:0] ad_out,     // registered, to pin inverters
   output logic        ad_ena,
   output logic        sync_o,
   output logic        din_o,
   output logic        dout_o,
   output logic        wtbt_o,
   output logic        iako_o,
   output logic        init_ena,   // open-drain init pin enable
   output logic        init_busy   // holds off the sequencer
);

   logic [vm2_pkg::init_cnt_w-1:0] init_cnt;   // cycles of init left

   always_ff @(posedge pin_clk_p) begin
      if (rst) begin
         init_cnt <= vm2_pkg::init_cnt_w'(vm2_pkg::init_cycles);
      end else if (init_cnt != '0) begin
         init_cnt <= init_cnt - 1'b1;
      end
   end

   assign init_ena  = (init_cnt != '0);
   assign init_busy = init_ena;

   // all strobes change on the same edge
   always_ff @(posedge pin_clk_p) begin
      if (rst || init_ena) begin
         ad_ena <= 1'b0;
         sync_o <= 1'b0;
         din_o  <= 1'b0;
         dout_o <= 1'b0;
         wtbt_o <= 1'b0;
         iako_o <= 1'b0;
      end else begin
         ad_ena <= ad_ena_d;
         sync_o <= sync_d;
         din_o  <= din_d;
         dout_o <= dout_d;
         wtbt_o <= wtbt_d;
         iako_o <= iako_d;
      end
   end

   always_ff @(posedge pin_clk_p) begin
      ad_out <= ad_out_d;                    // only seen while ad_ena
   end

endmodule

/* hdl/vm2.sv */
// top level of the qbus unit
// host request port, inverted qbus pins with tri-state ad bus
// and open-drain init, input sync, sequencer and pin drive
`timescale 1ns/1ps

module vm2 (
   input  logic              pin_clk_p,   // bus clock, rising edge
   input  logic              rst,         // sync reset, active high
   input  logic              pin_virq_n,  // vectored interrupt request
   input  logic              pin_rply_n,  // transaction reply
   inout  wire  [15:0]       pin_ad_n,    // inverted address/data
   output wire               pin_init_n,  // peripheral reset, open drain
   output logic              pin_sync_n,  // address strobe
   output logic              pin_wtbt_n,  // write/byte status
   output logic              pin_dout_n,  // data output strobe
   output logic              pin_din_n,   // data input strobe
   output logic              pin_iako_n,  // interrupt ack
   input  logic              req_strobe,  // host request pulse
   input  vm2_pkg::qbus_op_t req_op,
   input  logic [15:0]       req_addr,
   input  logic [15:0]       req_wdata,
   output logic              busy,
   output logic              done,
   output vm2_pkg::qbus_op_t done_op,
   output logic [15:0]       rd_data,
   output logic              bus_err
);

   logic        rply, virq;           // synchronized inputs
   logic [15:0] ad_in;
   logic [15:0] seq_ad_out;           // sequencer levels
   logic        seq_ad_ena, seq_sync, seq_din, seq_dout, seq_wtbt, seq_iako;
   logic [15:0] pin_ad_out;           // registered pin levels
   logic        pin_ad_ena, pin_sync, pin_din, pin_dout, pin_wtbt, pin_iako;
   logic        init_ena, init_busy;

   assign pin_ad_n   = pin_ad_ena ? ~pin_ad_out : 16'hzzzz;
   assign pin_sync_n = ~pin_sync;
   assign pin_din_n  = ~pin_din;
   assign pin_dout_n = ~pin_dout;
   assign pin_wtbt_n = ~pin_wtbt;
   assign pin_iako_n = ~pin_iako;
   assign pin_init_n = init_ena ? 1'b0 : 1'bz;   // pulled up outside

   vm2_pin_sync sync_inst (
      .pin_clk_p  (pin_clk_p),
      .rst        (rst),
      .rply_raw   (~pin_rply_n),
      .virq_raw   (~pin_virq_n),
      .ad_raw     (~pin_ad_n),                 // reads back own drive too
      .strobe_act (seq_din | seq_dout),
      .rply       (rply),
      .virq       (virq),
      .ad_in      (ad_in)
   );

   vm2_qbus_seq seq_inst (
      .pin_clk_p  (pin_clk_p),
      .rst        (rst),
      .init_busy  (init_busy),
      .req_strobe (req_strobe),
      .req_op     (req_op),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .rply       (rply),
      .virq       (virq),
      .ad_in      (ad_in),
      .busy       (busy),
      .done       (done),
      .done_op    (done_op),
      .rd_data    (rd_data),
      .bus_err    (bus_err),
      .ad_out     (seq_ad_out),
      .ad_ena     (seq_ad_ena),
      .sync       (seq_sync),
      .din        (seq_din),
      .dout       (seq_dout),
      .wtbt       (seq_wtbt),
      .iako       (seq_iako)
   );

   vm2_pin_drive drive_inst (
      .pin_clk_p  (pin_clk_p),
      .rst        (rst),
      .ad_out_d   (seq_ad_out),
      .ad_ena_d   (seq_ad_ena),
      .sync_d     (seq_sync),
      .din_d      (seq_din),
      .dout_d     (seq_dout),
      .wtbt_d     (seq_wtbt),
      .iako_d     (seq_iako),
      .ad_out     (pin_ad_out),
      .ad_ena     (pin_ad_ena),
      .sync_o     (pin_sync),
      .din_o      (pin_din),
      .dout_o     (pin_dout),
      .wtbt_o     (pin_wtbt),
      .iako_o     (pin_iako),
      .init_ena   (init_ena),
      .init_busy  (init_busy)
   );

endmodule

/* sim/qbus_slave_model.sv */
// behavioral qbus slave for the testbench
// 4096-word memory with random reply delay, interrupt source with vector
`timescale 1ns/1ps

module qbus_slave_model #(
   parameter int          seed_init  = 77,
   parameter logic [15:0] vector     = 16'o000100,
   parameter logic [15:0] nodev_base = 16'o160000   // silent from here up
) (
   input  logic        clk,
   input  logic        irq_set,      // raise virq until acknowledged
   input  logic        pin_sync_n,
   input  logic        pin_din_n,
   input  logic        pin_dout_n,
   input  logic        pin_wtbt_n,
   input  logic        pin_iako_n,
   inout  wire  [15:0] pin_ad_n,
   output logic        pin_rply_n,
   output logic        pin_virq_n
);

   logic [15:0] mem [4096];
   logic [15:0] addr_q;      // latched at the start of sync
   logic [15:0] ad_drv;
   logic        ad_ena;
   logic        rply;
   logic        irq_pend;
   logic        sync_q;      // sync seen on the last edge
   int          delay;       // -1 until a strobe is seen
   integer      seed;

   assign pin_ad_n   = ad_ena ? ~ad_drv : 16'hzzzz;
   assign pin_rply_n = ~rply;
   assign pin_virq_n = ~irq_pend;

   initial begin
      seed     = seed_init;
      addr_q   = '0;
      ad_drv   = '0;
      ad_ena   = 1'b0;
      rply     = 1'b0;
      irq_pend = 1'b0;
      sync_q   = 1'b0;
      delay    = -1;
      for (int i = 0; i < 4096; i++) begin
         mem[i] = 16'(i * 40503) ^ 16'h6b3e;      // odd multiplier, all address bits count
      end
   end

   // falling edge, half a cycle away from the pin register edge
   always @(negedge clk) begin
      logic [15:0] wdata;
      logic [11:0] idx;
      wdata = ~pin_ad_n;
      idx   = addr_q[12:1];                        // word index
      if (irq_set) begin
         irq_pend <= 1'b1;
      end
      if (!pin_sync_n && !sync_q) begin
         addr_q <= ~pin_ad_n;                      // address still on ad
      end
      sync_q <= !pin_sync_n;
      if (pin_din_n && pin_dout_n) begin           // strobe gone, let go
         rply   <= 1'b0;
         ad_ena <= 1'b0;
         delay  <= -1;
      end else if (!rply) begin
         if (delay < 0) begin
            delay <= $unsigned($random(seed)) % 8;
         end else if (delay > 0) begin
            delay <= delay - 1;
         end else if (!pin_iako_n) begin          // vector read, no address
            ad_drv   <= vector;
            ad_ena   <= 1'b1;
            rply     <= 1'b1;
            irq_pend <= 1'b0;
         end else if (addr_q < nodev_base) begin
            rply <= 1'b1;
            if (!pin_din_n) begin
               ad_drv <= mem[idx];
               ad_ena <= 1'b1;
            end else if (!pin_wtbt_n && addr_q[0]) begin
               mem[idx][15:8] <= wdata[15:8];      // odd byte on the high lines
            end else if (!pin_wtbt_n) begin
               mem[idx][7:0] <= wdata[7:0];
            end else begin
               mem[idx] <= wdata;
            end
         end
      end
   end

endmodule

/* sim/tb_vm2.sv */
// testbench for the qbus unit
// clock and reset, stimulus, memory reference model, compare tasks, watchdog
`timescale 1ns/1ps

module tb_vm2;

   localparam int          seed_init  = 77;
   localparam logic [15:0] nodev_base = 16'o160000;   // no reply here and above
   localparam logic [15:0] vector     = 16'o000100;
   localparam int          mem_words  = 4096;
   localparam int          num_words  = 16;            // write then read pairs
   localparam int          num_bytes  = 4;             // groups of 5 cycles
   localparam int          test_count = 2 * num_words + 5 * num_bytes + 6;
   localparam int          op_limit   = vm2_pkg::rply_timeout + 40;
   localparam int          watchdog_cycles = test_count * op_limit + vm2_pkg::init_cycles + 100;

   logic              clk;
   logic              rst;
   logic              req_strobe;
   vm2_pkg::qbus_op_t req_op;
   logic [15:0]       req_addr;
   logic [15:0]       req_wdata;
   logic              busy, done, bus_err;
   vm2_pkg::qbus_op_t done_op;
   logic [15:0]       rd_data;
   logic              irq_set;                          // pulse to the slave
   tri1  [15:0]       pin_ad_n;                         // pulled up when floating
   tri1               pin_init_n;                       // open drain
   logic              pin_sync_n, pin_wtbt_n, pin_dout_n, pin_din_n, pin_iako_n;
   logic              pin_virq_n, pin_rply_n;

   integer            seed;
   int                errors = 0;
   int                done_cnt = 0;                     // done pulses checked
   int                iako_cnt = 0;
   logic [15:0]       ref_mem [mem_words];
   logic [15:0]       word_addr [num_words];
   string             exp_name_q [$];                   // expectations, oldest first
   vm2_pkg::qbus_op_t exp_op_q [$];
   logic [15:0]       exp_data_q [$];
   logic              exp_err_q [$];
   bit                exp_chk_q [$];                    // rd_data is compared

   vm2 vm2_inst (
      .pin_clk_p (clk), .rst (rst), .pin_virq_n (pin_virq_n), .pin_rply_n (pin_rply_n),
      .pin_ad_n (pin_ad_n), .pin_init_n (pin_init_n), .pin_sync_n (pin_sync_n),
      .pin_wtbt_n (pin_wtbt_n), .pin_dout_n (pin_dout_n), .pin_din_n (pin_din_n),
      .pin_iako_n (pin_iako_n), .req_strobe (req_strobe), .req_op (req_op),
      .req_addr (req_addr), .req_wdata (req_wdata), .busy (busy), .done (done),
      .done_op (done_op), .rd_data (rd_data), .bus_err (bus_err)
   );

   qbus_slave_model #(.seed_init (seed_init), .vector (vector), .nodev_base (nodev_base))
   slave_inst (
      .clk (clk), .irq_set (irq_set), .pin_sync_n (pin_sync_n), .pin_din_n (pin_din_n),
      .pin_dout_n (pin_dout_n), .pin_wtbt_n (pin_wtbt_n), .pin_iako_n (pin_iako_n),
      .pin_ad_n (pin_ad_n), .pin_rply_n (pin_rply_n), .pin_virq_n (pin_virq_n)
   );

   task automatic fail_run(input string msg);
      errors++;
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp) fail_run($sformatf("MISMATCH %s expected %o actual %o", name, exp, act));
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
   endtask

   task automatic check_op(input string name, input vm2_pkg::qbus_op_t exp,
                           input vm2_pkg::qbus_op_t act);
      if (act !== exp) begin
         fail_run($sformatf("MISMATCH %s expected %s actual %s", name, exp.name(), act.name()));
      end
   endtask

   // memory as the slave should hold it, byte lane picked by a[0]
   function automatic logic [15:0] ref_access(input vm2_pkg::qbus_op_t op, input logic [15:0] addr,
                                              input logic [15:0] wdata, output logic err);
      logic [11:0] idx;
      idx = addr[12:1];
      err = (op != vm2_pkg::op_iack) && (addr >= nodev_base);
      if (err) return 16'h0000;
      case (op)
         vm2_pkg::op_read:  return ref_mem[idx];
         vm2_pkg::op_iack:  return vector;
         vm2_pkg::op_write: ref_mem[idx] = wdata;
         default: begin
            if (addr[0]) ref_mem[idx][15:8] = wdata[15:8];
            else ref_mem[idx][7:0] = wdata[7:0];
         end
      endcase
      return 16'h0000;
   endfunction

   task automatic expect_done(input string name, input vm2_pkg::qbus_op_t op,
                              input logic [15:0] data, input logic err, input bit chk);
      exp_name_q.push_back(name);
      exp_op_q.push_back(op);
      exp_data_q.push_back(data);
      exp_err_q.push_back(err);
      exp_chk_q.push_back(chk);
   endtask

   task automatic queue_op(input string name, input vm2_pkg::qbus_op_t op,
                           input logic [15:0] addr, input logic [15:0] wdata);
      logic [15:0] data;
      logic        err;
      data = ref_access(op, addr, wdata, err);
      expect_done(name, op, data, err, (op == vm2_pkg::op_read) && !err);
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      @(negedge clk);
      while (busy !== 1'b0) begin
         @(negedge clk);
         n++;
         if (n > op_limit) fail_run("DUT stayed busy and took no new request");
      end
   endtask

   task automatic send_req(input vm2_pkg::qbus_op_t op, input logic [15:0] addr,
                           input logic [15:0] wdata);
      @(posedge clk);
      req_strobe <= 1'b1;
      req_op     <= op;
      req_addr   <= addr;
      req_wdata  <= wdata;
      @(posedge clk);
      req_strobe <= 1'b0;
   endtask

   task automatic wait_for_done(input int target);
      int n;
      n = 0;
      while (done_cnt < target) begin
         @(negedge clk);
         n++;
         if (n > 2 * op_limit) fail_run("bus cycle never finished with a done pulse");
      end
   endtask

   task automatic run_op(input string name, input vm2_pkg::qbus_op_t op,
                         input logic [15:0] addr, input logic [15:0] wdata);
      int target;
      target = done_cnt + 1;
      queue_op(name, op, addr, wdata);
      wait_idle();
      send_req(op, addr, wdata);
      wait_for_done(target);
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;                         // 100 ns period
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      fail_run($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
   end

   // compares every done pulse with the oldest expectation
   always @(negedge clk) begin
      if (!rst && done === 1'b1) begin
         if (exp_op_q.size() == 0) begin
            fail_run("done pulse with no bus cycle outstanding");
         end else begin
            check_op({exp_name_q[0], " done_op"}, exp_op_q[0], done_op);
            check_err({exp_name_q[0], " bus_err"}, exp_err_q[0], bus_err);
            if (exp_chk_q[0]) check_data({exp_name_q[0], " rd_data"}, exp_data_q[0], rd_data);
            void'(exp_name_q.pop_front());
            void'(exp_op_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_err_q.pop_front());
            void'(exp_chk_q.pop_front());
            done_cnt++;
         end
      end
   end

   always @(negedge clk) begin
      if (pin_iako_n === 1'b0) iako_cnt++;
   end

   initial begin
      logic [15:0] a;
      int          init_len;
      int          iako_before;
      int          target;
      seed       = seed_init;
      rst        = 1'b1;
      req_strobe = 1'b0;
      req_op     = vm2_pkg::op_read;
      req_addr   = '0;
      req_wdata  = '0;
      irq_set    = 1'b0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      // init pulse length, busy held through it
      init_len = 0;
      @(negedge clk);
      while (pin_init_n === 1'b0) begin
         if (busy !== 1'b1) fail_run("busy dropped while pin_init_n was still low");
         init_len++;
         @(negedge clk);
      end
      check_data("init pulse cycles", 16'(vm2_pkg::init_cycles), 16'(init_len));
      check_err("busy after init", 1'b0, busy);

      for (int i = 0; i < num_words; i++) begin
         word_addr[i] = {3'b000, 12'($random(seed)), 1'b0};
         run_op($sformatf("word write %0d", i), vm2_pkg::op_write, word_addr[i],
                16'($random(seed)));
      end
      for (int i = 0; i < num_words; i++) begin
         run_op($sformatf("word read %0d", i), vm2_pkg::op_read, word_addr[i], 16'h0000);
      end

      for (int i = 0; i < num_bytes; i++) begin
         a = {3'b000, 12'($random(seed)), 1'b0};
         run_op($sformatf("byte base %0d", i), vm2_pkg::op_write, a, 16'($random(seed)));
         run_op($sformatf("byte even %0d", i), vm2_pkg::op_write_byte, a, 16'($random(seed)));
         run_op($sformatf("byte even read %0d", i), vm2_pkg::op_read, a, 16'h0000);
         run_op($sformatf("byte odd %0d", i), vm2_pkg::op_write_byte, a | 16'h0001,
                16'($random(seed)));
         run_op($sformatf("byte odd read %0d", i), vm2_pkg::op_read, a, 16'h0000);
      end

      run_op("read no device", vm2_pkg::op_read, nodev_base, 16'h0000);
      run_op("write no device", vm2_pkg::op_write, 16'o177776, 16'o123456);
      run_op("read after bus error", vm2_pkg::op_read, word_addr[0], 16'h0000);

      iako_before = iako_cnt;
      wait_idle();
      target = done_cnt + 1;
      expect_done("interrupt ack", vm2_pkg::op_iack, vector, 1'b0, 1'b1);
      @(posedge clk);
      irq_set <= 1'b1;
      @(posedge clk);
      irq_set <= 1'b0;
      wait_for_done(target);
      if (iako_cnt == iako_before) fail_run("pin_iako_n never went low during the iack cycle");

      // virq reaches the sequencer sync_stages edges after the slave sees irq_set,
      // the same edge as this request
      wait_idle();
      target = done_cnt + 2;
      @(posedge clk);
      irq_set <= 1'b1;
      @(posedge clk);
      irq_set <= 1'b0;
      queue_op("tie host read", vm2_pkg::op_read, word_addr[1], 16'h0000);
      expect_done("tie interrupt ack", vm2_pkg::op_iack, vector, 1'b0, 1'b1);
      send_req(vm2_pkg::op_read, word_addr[1], 16'h0000);
      wait_for_done(target);

      repeat (5) @(posedge clk);
      if (errors == 0 && exp_op_q.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         fail_run("run ended with bus cycles still unchecked");
      end
   end

endmodule

/* project.f */
common/vm2_pkg.sv
hdl/vm2_pin_sync.sv
qbus/vm2_qbus_seq.sv
hdl/vm2_pin_drive.sv
hdl/vm2.sv
sim/qbus_slave_model.sv
sim/tb_vm2.sv

/* Bender.yml */
package:
  name: vm2

sources:
  - common/vm2_pkg.sv
  - hdl/vm2_pin_sync.sv
  - qbus/vm2_qbus_seq.sv
  - hdl/vm2_pin_drive.sv
  - hdl/vm2.sv
  - target: simulation
    files:
      - sim/qbus_slave_model.sv
      - sim/tb_vm2.sv
